/* beeb_host.f */
logic/beeb_pkg.sv
logic/clk_enables.sv
logic/rom_image.sv
logic/beeb_memory.sv
logic/mouse_axis_emu.sv
logic/joystick_router.sv
logic/beeb_host.sv
bench/beeb_host_props.sv
bench/beeb_host_tb.sv

/* bench/beeb_host_props.sv */
// memory and enable properties
`timescale 1ns/1ps

module beeb_host_props (
	input logic                clk_sys,
	input logic                rst_n,
	input beeb_pkg::mem_req_t  mem_req,
	input beeb_pkg::host_cfg_t cfg,
	input logic                reset_req,
	input logic [7:0]          mem_rdata,
	input logic                ce_24,
	input logic                ce_32
);

	// model as the core last requested it
	logic model_seen;
	logic rom_miss;

	// sockets with no image behind them
	function automatic logic bank_empty(input logic m128, input logic [3:0] bank);
		if (m128)
			return !((bank inside {4'h2, 4'h3, 4'h4}) || (bank >= 4'h9));
		return !(bank inside {4'h4, 4'h8, 4'he, 4'hf});
	endfunction

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			model_seen <= 1'b0;
		else if (reset_req)
			model_seen <= cfg.model_m128;
	end

	assign rom_miss = !mem_req.addr.rom.region &&
		bank_empty(model_seen, {mem_req.addr.rom.grp, mem_req.addr.rom.idx});

	// ========================================
	// clock enables
	// ========================================
	ce_24_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_24 |=> !ce_24 ##1 !ce_24 ##1 !ce_24 ##1 ce_24)
		else $error("ce_24 does not repeat every 4 cycles");

	ce_32_period: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_32 |=> !ce_32 ##1 !ce_32 ##1 ce_32)
		else $error("ce_32 does not repeat every 3 cycles");

	ce_low_in_reset: assert property (@(posedge clk_sys)
		!rst_n |=> !ce_24 && !ce_32)
		else $error("clock enable active while held in reset");

	// ========================================
	// read data
	// ========================================
	rdata_zero_in_reset: assert property (@(posedge clk_sys)
		!rst_n |=> mem_rdata == 8'h00)
		else $error("read data not cleared by reset");

	// empty bank reads zero one cycle later
	rom_miss_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_miss |=> mem_rdata == 8'h00)
		else $error("read of an empty rom bank returned nonzero data");

endmodule

bind beeb_host beeb_host_props u_props (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.mem_req   (mem_req),
	.cfg       (cfg),
	.reset_req (reset_req),
	.mem_rdata (mem_rdata),
	.ce_24     (ce_24),
	.ce_32     (ce_32)
);

/* bench/beeb_host_tb.sv */
// bbc micro host testbench
`timescale 1ns/1ps

module beeb_host_tb;

	// ========================================
	// run lengths
	// ========================================
	localparam int CLK_NS       = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CE_CYCLES    = 24;
	// offset pairs per bank and model
	localparam int ROM_OFFS     = 6;
	localparam int RAM_WRITES   = 48;
	localparam int MOUSE_PKTS   = 40;
	localparam int SWAP_ROUNDS  = 32;
	// upper bound of each test in cycles
	localparam int TEST_CYCLES  = RESET_CYCLES + CE_CYCLES
		+ (beeb_pkg::ROM_WORDS + 4)
		+ 2 * (2 + 2 * 16 * ROM_OFFS)
		+ (RAM_WRITES * 7 + 8)
		+ (MOUSE_PKTS + 64)
		+ 16
		+ SWAP_ROUNDS * 2;
	// 20 percent margin
	localparam longint WATCHDOG_NS = longint'(TEST_CYCLES) * CLK_NS * 12 / 10;

	logic                 clk_sys;
	logic                 rst_n;
	beeb_pkg::mem_req_t   mem_req;
	beeb_pkg::rom_load_t  rom_load;
	beeb_pkg::host_cfg_t  cfg;
	logic                 reset_req;
	beeb_pkg::mouse_pkt_t mouse;
	beeb_pkg::axis_pair_t joy1_axes;
	beeb_pkg::axis_pair_t joy2_axes;
	logic [15:0]          joy1_btn;
	logic [15:0]          joy2_btn;
	logic [7:0]           mem_rdata;
	logic                 ce_24;
	logic                 ce_32;
	beeb_pkg::beeb_joy_t  joy_a;
	beeb_pkg::beeb_joy_t  joy_b;

	// reference state
	logic [15:0]          rom_ref [beeb_pkg::ROM_WORDS];
	logic [7:0]           ram_ref [int];
	int                   ram_addrs [$];
	logic                 model_ref;
	logic                 emu_ref;
	logic                 strobe_ref;
	int                   px_ref;
	int                   py_ref;

	beeb_host #(
		.MOUSE_STEP_MAX (10)
	) dut0 (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.rom_load  (rom_load),
		.cfg       (cfg),
		.reset_req (reset_req),
		.mouse     (mouse),
		.joy1_axes (joy1_axes),
		.joy2_axes (joy2_axes),
		.joy1_btn  (joy1_btn),
		.joy2_btn  (joy2_btn),
		.mem_rdata (mem_rdata),
		.ce_24     (ce_24),
		.ce_32     (ce_32),
		.joy_a     (joy_a),
		.joy_b     (joy_b)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("TEST FAIL");
		$fatal(1, "watchdog timeout");
	end

	// ========================================
	// helpers
	// ========================================
	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int clamp(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// physical slot per model and bank, -1 for an empty socket
	function automatic int slot_ref(input logic m128, input logic [3:0] bank);
		int b;
		b = int'(bank);
		if (!m128) begin
			case (b)
				4:       return 0;
				8:       return 1;
				14:      return 2;
				15:      return 3;
				default: return -1;
			endcase
		end
		if (b == 2 || b == 3)
			return b + 2;
		if (b == 4)
			return 6;
		if (b >= 9)
			return b - 2;
		return -1;
	endfunction

	// inverted offset binary with the top nibble repeated
	function automatic logic [11:0] axis_code(input logic [7:0] v);
		logic [7:0] u;
		u = 8'd255 - (v ^ 8'h80);
		return {u, u[7:4]};
	endfunction

	// one clock with the mouse and model reference kept in step
	task automatic step();
		logic clear;
		int   dx;
		int   dy;
		clear = !rst_n || reset_req || cfg.mouse_off || (joy1_btn != 16'h0);
		dx    = int'($signed({mouse.x_sign, mouse.x_mov}));
		dy    = int'($signed({mouse.y_sign, mouse.y_mov}));
		@(posedge clk_sys);
		#1;
		if (!rst_n)
			model_ref = 1'b0;
		else if (reset_req)
			model_ref = cfg.model_m128;
		if (clear) begin
			emu_ref = 1'b0;
			px_ref  = 0;
			py_ref  = 0;
		end else if (mouse.strobe != strobe_ref) begin
			emu_ref = 1'b1;
			px_ref  = clamp(px_ref + clamp(dx, -10, 10), -128, 127);
			py_ref  = clamp(py_ref - clamp(dy, -10, 10), -128, 127);
		end
		strobe_ref = mouse.strobe;
	endtask

	task automatic check_joy(input string name);
		beeb_pkg::beeb_joy_t a;
		beeb_pkg::beeb_joy_t b;
		if (emu_ref) begin
			a.x      = axis_code(px_ref[7:0]);
			a.y      = axis_code(py_ref[7:0]);
			a.fire_n = ~(mouse.btn[0] | mouse.btn[1]);
		end else begin
			a.x      = axis_code(joy1_axes.x);
			a.y      = axis_code(joy1_axes.y);
			a.fire_n = ~joy1_btn[4];
		end
		b.x      = axis_code(joy2_axes.x);
		b.y      = axis_code(joy2_axes.y);
		b.fire_n = ~joy2_btn[4];
		if (cfg.swap_joy) begin
			expect_eq($sformatf("%s joy_a", name), b, joy_a);
			expect_eq($sformatf("%s joy_b", name), a, joy_b);
		end else begin
			expect_eq($sformatf("%s joy_a", name), a, joy_a);
			expect_eq($sformatf("%s joy_b", name), b, joy_b);
		end
	endtask

	task automatic send_packet(input int dx, input int dy, input logic [1:0] btn);
		logic [8:0] mx;
		logic [8:0] my;
		mx           = 9'(dx);
		my           = 9'(dy);
		mouse.strobe = ~mouse.strobe;
		mouse.x_sign = mx[8];
		mouse.x_mov  = mx[7:0];
		mouse.y_sign = my[8];
		mouse.y_mov  = my[7:0];
		mouse.btn    = btn;
	endtask

	// model changes only through a core reset request
	task automatic set_model(input logic m128);
		cfg.model_m128 = m128;
		reset_req      = 1'b1;
		step();
		reset_req = 1'b0;
	endtask

	task automatic rom_read(input logic [3:0] bank, input logic [13:0] off);
		int          slot;
		logic [15:0] word;
		logic [7:0]  exp;
		mem_req.we_n            = 1'b1;
		mem_req.addr.rom.region = 1'b0;
		mem_req.addr.rom.grp    = bank[3:2];
		mem_req.addr.rom.idx    = bank[1:0];
		mem_req.addr.rom.offset = off;
		step();
		slot = slot_ref(model_ref, bank);
		if (slot < 0) begin
			exp = 8'h00;
		end else begin
			word = rom_ref[slot * 8192 + int'(off[13:1])];
			exp  = off[0] ? word[7:0] : word[15:8];
		end
		expect_eq($sformatf("rom map m%0d bank %0h off %0h", model_ref, bank, off),
			exp, mem_rdata);
	endtask

	// later data on a held strobe must not land
	task automatic ram_write(input int addr, input logic [7:0] data, input int hold);
		mem_req.we_n               = 1'b0;
		mem_req.addr.ram.region    = 1'b1;
		mem_req.addr.ram.byte_addr = 18'(addr);
		mem_req.wdata              = data;
		step();
		ram_ref[addr] = data;
		ram_addrs.push_back(addr);
		for (int i = 1; i < hold; i++) begin
			mem_req.wdata = ~data ^ 8'(i);
			step();
		end
		mem_req.we_n = 1'b1;
	endtask

	task automatic ram_read(input string name, input int addr);
		mem_req.we_n               = 1'b1;
		mem_req.addr.ram.region    = 1'b1;
		mem_req.addr.ram.byte_addr = 18'(addr);
		step();
		expect_eq($sformatf("%s addr %0h", name, addr), ram_ref[addr], mem_rdata);
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		logic [13:0] off;
		logic [17:0] a18;
		logic [7:0]  data;
		int          addr;
		int          hold;

		rst_n        = 1'b0;
		mem_req      = '0;
		mem_req.we_n = 1'b1;
		rom_load     = '0;
		cfg          = '0;
		reset_req    = 1'b0;
		mouse        = '0;
		joy1_axes    = '0;
		joy2_axes    = '0;
		joy1_btn     = 16'h0;
		joy2_btn     = 16'h0;
		model_ref    = 1'b0;
		emu_ref      = 1'b0;
		strobe_ref   = 1'b0;
		px_ref       = 0;
		py_ref       = 0;
		void'($urandom(32'h00f3_f594));

		// enables held off, then first pulse right after release
		repeat (RESET_CYCLES) begin
			step();
			expect_eq("ce_24 in reset", 1'b0, ce_24);
			expect_eq("ce_32 in reset", 1'b0, ce_32);
		end
		rst_n = 1'b1;
		for (int i = 0; i < CE_CYCLES; i++) begin
			step();
			expect_eq($sformatf("ce_24 cycle %0d", i), (i % 4 == 0), ce_24);
			expect_eq($sformatf("ce_32 cycle %0d", i), (i % 3 == 0), ce_32);
		end

		// fill every slot through the loader under reset
		rst_n = 1'b0;
		for (int w = 0; w < beeb_pkg::ROM_WORDS; w++) begin
			rom_ref[w]    = 16'($urandom);
			rom_load.wr   = 1'b1;
			rom_load.addr = 17'(w);
			rom_load.data = rom_ref[w];
			step();
		end
		// a load once running must be dropped
		rst_n         = 1'b1;
		rom_load.addr = '0;
		rom_load.data = ~rom_ref[0];
		step();
		rom_load.wr = 1'b0;

		// every bank, both byte lanes, both models
		for (int m = 0; m < 2; m++) begin
			set_model(1'(m));
			for (int b = 0; b < 16; b++) begin
				for (int k = 0; k < ROM_OFFS; k++) begin
					off = (k == 0) ? 14'h0 : (14'($urandom) & 14'h3ffe);
					rom_read(4'(b), off);
					rom_read(4'(b), off | 14'h1);
				end
			end
		end

		// ram writes with long strobes
		for (int i = 0; i < RAM_WRITES; i++) begin
			addr = int'($urandom % beeb_pkg::RAM_BYTES);
			data = 8'($urandom);
			hold = 1 + int'($urandom % 4);
			ram_write(addr, data, hold);
			ram_read("ram readback", addr);
		end
		foreach (ram_addrs[i])
			ram_read("ram final readback", ram_addrs[i]);

		// write strobe outside the ram region
		addr                       = ram_addrs[0];
		a18                        = 18'(addr);
		mem_req.we_n               = 1'b0;
		mem_req.addr.ram.region    = 1'b0;
		mem_req.addr.ram.byte_addr = a18;
		mem_req.wdata              = ~ram_ref[addr];
		step();
		mem_req.we_n = 1'b1;
		ram_read("ram after rom region write", addr);
		rom_read(a18[17:14], a18[13:0]);
		rom_read(a18[17:14], a18[13:0] ^ 14'h1);

		// mouse saturation in both directions
		step();
		check_joy("mouse idle");
		for (int i = 0; i < 15; i++) begin
			send_packet(200, -200, 2'b00);
			step();
			check_joy($sformatf("mouse high %0d", i));
		end
		for (int i = 0; i < 30; i++) begin
			send_packet(-240, 250, 2'b01);
			step();
			check_joy($sformatf("mouse low %0d", i));
		end
		// movement without a strobe change is no packet
		mouse.x_mov = 8'h05;
		step();
		check_joy("mouse stale packet");
		for (int i = 0; i < MOUSE_PKTS; i++) begin
			if (i % 2 == 0)
				send_packet(int'($urandom % 25) - 12, int'($urandom % 25) - 12, 2'($urandom));
			else
				send_packet(int'($urandom % 512) - 256, int'($urandom % 512) - 256,
					2'($urandom));
			step();
			check_joy($sformatf("mouse random %0d", i));
		end

		// pad activity and disable both hand port a back
		send_packet(5, -3, 2'b01);
		step();
		check_joy("clear setup");
		joy1_axes = 16'($urandom);
		joy1_btn  = 16'h0001;
		send_packet(7, 7, 2'b10);
		step();
		check_joy("clear by pad button");
		joy1_btn = 16'h0010;
		step();
		check_joy("pad fire");
		joy1_btn = 16'h0000;
		step();
		check_joy("pad idle");
		send_packet(-4, 6, 2'b11);
		step();
		check_joy("mouse again");
		cfg.mouse_off = 1'b1;
		send_packet(3, 3, 2'b00);
		step();
		check_joy("clear by mouse_off");
		send_packet(3, 3, 2'b01);
		step();
		check_joy("mouse disabled");
		cfg.mouse_off = 1'b0;

		// port swap with mixed sources
		for (int r = 0; r < SWAP_ROUNDS; r++) begin
			joy1_axes    = 16'($urandom);
			joy2_axes    = 16'($urandom);
			joy2_btn     = 16'($urandom);
			joy1_btn     = ($urandom % 3 == 0) ? 16'($urandom) : 16'h0000;
			cfg.swap_joy = 1'($urandom);
			if ($urandom % 2 == 1)
				send_packet(int'($urandom % 21) - 10, int'($urandom % 21) - 10, 2'($urandom));
			step();
			check_joy($sformatf("swap round %0d", r));
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

/* logic/beeb_host.sv */
// bbc micro host glue
`timescale 1ns/1ps

module beeb_host #(
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  beeb_pkg::mem_req_t   mem_req,
	input  beeb_pkg::rom_load_t  rom_load,
	input  beeb_pkg::host_cfg_t  cfg,
	input  logic                 reset_req,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  beeb_pkg::axis_pair_t joy1_axes,
	input  beeb_pkg::axis_pair_t joy2_axes,
	input  logic [15:0]          joy1_btn,
	input  logic [15:0]          joy2_btn,
	output logic [7:0]           mem_rdata,
	output logic                 ce_24,
	output logic                 ce_32,
	output beeb_pkg::beeb_joy_t  joy_a,
	output beeb_pkg::beeb_joy_t  joy_b
);

	// mouse emulation to router
	beeb_pkg::axis_pair_t mouse_pos;
	logic                 emu_on;
	logic                 emu_fire;
	logic                 joy1_active;

	// ========================================
	// timing
	// ========================================
	clk_enables u_ce (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_24   (ce_24),
		.ce_32   (ce_32)
	);

	// ========================================
	// memory bus
	// ========================================
	beeb_memory u_mem (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.mem_req    (mem_req),
		.rom_load   (rom_load),
		.model_m128 (cfg.model_m128),
		.reset_req  (reset_req),
		.mem_rdata  (mem_rdata)
	);

	// ========================================
	// analog inputs
	// ========================================
	mouse_axis_emu #(
		.MOUSE_STEP_MAX (MOUSE_STEP_MAX)
	) u_mouse (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.mouse       (mouse),
		.joy1_active (joy1_active),
		.reset_req   (reset_req),
		.mouse_off   (cfg.mouse_off),
		.pos         (mouse_pos),
		.emu_on      (emu_on),
		.emu_fire    (emu_fire)
	);

	joystick_router u_joy (
		.pos         (mouse_pos),
		.emu_on      (emu_on),
		.emu_fire    (emu_fire),
		.joy1_axes   (joy1_axes),
		.joy2_axes   (joy2_axes),
		.joy1_btn    (joy1_btn),
		.joy2_btn    (joy2_btn),
		.swap_joy    (cfg.swap_joy),
		.joy1_active (joy1_active),
		.joy_a       (joy_a),
		.joy_b       (joy_b)
	);

endmodule

/* logic/beeb_memory.sv */
// core external memory
`timescale 1ns/1ps

module beeb_memory (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  beeb_pkg::mem_req_t  mem_req,
	input  beeb_pkg::rom_load_t rom_load,
	input  logic                model_m128,
	input  logic                reset_req,
	output logic [7:0]          mem_rdata
);

	logic [7:0] ram_mem [beeb_pkg::RAM_BYTES];
	logic [7:0] ram_q;
	logic       we_n_q;
	logic       model_q;
	logic       region_q;
	logic       ram_we;
	logic [7:0] rom_byte;

	// ========================================
	// ram
	// ========================================
	// write only on the falling edge of we_n
	// top of the 18-bit space is not populated
	assign ram_we = mem_req.addr.ram.region && we_n_q && !mem_req.we_n &&
		(mem_req.addr.ram.byte_addr < 18'(beeb_pkg::RAM_BYTES));

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram_mem[mem_req.addr.ram.byte_addr] <= mem_req.wdata;
		ram_q <= ram_mem[mem_req.addr.ram.byte_addr];
	end

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			we_n_q   <= 1'b1;
			model_q  <= 1'b0;
			region_q <= 1'b0;
		end else begin
			we_n_q   <= mem_req.we_n;
			region_q <= mem_req.addr.ram.region;
			// model follows the option only during a core reset
			if (reset_req)
				model_q <= model_m128;
		end
	end

	rom_image u_rom (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rom_load (rom_load),
		.model    (model_q),
		.addr     (mem_req.addr),
		.rom_byte (rom_byte)
	);

	// region bit lines up with both registered reads
	assign mem_rdata = region_q ? ram_q : rom_byte;

endmodule

/* logic/beeb_pkg.sv */
// bbc micro host shared types
package beeb_pkg;

	// ========================================
	// memory sizes
	// ========================================
	// physical rom slots, 16 KB each
	localparam int ROM_SLOTS      = 14;
	localparam int ROM_SLOT_WORDS = 8192;
	localparam int ROM_WORDS      = ROM_SLOTS * ROM_SLOT_WORDS;
	localparam int ROM_AW         = 17;
	// main, shadow, sideways and fs ram
	localparam int RAM_BYTES      = 212992;
	localparam int RAM_AW         = 18;

	// ========================================
	// core memory bus
	// ========================================
	// bit 18 high selects the ram region
	typedef struct packed {
		logic              region;
		logic [RAM_AW-1:0] byte_addr;
	} ram_view_t;

	// rom side splits into 16 banks of 16 KB
	typedef struct packed {
		logic        region;
		logic [1:0]  grp;
		logic [1:0]  idx;
		logic [13:0] offset;
	} rom_view_t;

	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} mem_addr_t;

	typedef struct packed {
		logic       we_n;
		mem_addr_t  addr;
		logic [7:0] wdata;
	} mem_req_t;

	// host loader word, even byte in the upper half
	typedef struct packed {
		logic              wr;
		logic [ROM_AW-1:0] addr;
		logic [15:0]       data;
	} rom_load_t;

	// ========================================
	// input devices
	// ========================================
	// ps/2 packet with the toggle strobe on top
	typedef struct packed {
		logic       strobe;
		logic [7:0] y_mov;
		logic [7:0] x_mov;
		logic [1:0] ovf;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] pad;
		logic [1:0] btn;
	} mouse_pkt_t;

	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} axis_pair_t;

	// one analog port as the core sees it
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic        fire_n;
	} beeb_joy_t;

	typedef struct packed {
		logic model_m128;
		logic mouse_off;
		logic swap_joy;
	} host_cfg_t;

	typedef struct packed {
		logic       hit;
		logic [3:0] slot;
	} rom_slot_t;

	// logical bank to physical slot, per model
	function automatic rom_slot_t rom_slot_of(input logic model_m128, input logic [3:0] bank);
		rom_slot_t r;
		r.hit  = 1'b1;
		r.slot = 4'd0;
		case ({model_m128, bank})
			// model b: os, mmfs, ram master, basic 2
			5'b0_0100: r.slot = 4'd0;
			5'b0_1000: r.slot = 4'd1;
			5'b0_1110: r.slot = 4'd2;
			5'b0_1111: r.slot = 4'd3;
			// master 128 set
			5'b1_0010: r.slot = 4'd4;
			5'b1_0011: r.slot = 4'd5;
			5'b1_0100: r.slot = 4'd6;
			5'b1_1001: r.slot = 4'd7;
			5'b1_1010: r.slot = 4'd8;
			5'b1_1011: r.slot = 4'd9;
			5'b1_1100: r.slot = 4'd10;
			5'b1_1101: r.slot = 4'd11;
			5'b1_1110: r.slot = 4'd12;
			5'b1_1111: r.slot = 4'd13;
			// empty sockets
			default:   r.hit  = 1'b0;
		endcase
		return r;
	endfunction

endpackage

/* logic/clk_enables.sv */
// core clock enables
`timescale 1ns/1ps

module clk_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_24,
	output logic ce_32
);

	// ========================================
	// dividers
	// ========================================
	// modulo 4 for the 24 MHz domain
	logic [1:0] div_24;
	// modulo 3 for the 32 MHz domain
	logic [1:0] div_32;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_24 <= 2'd0;
			div_32 <= 2'd0;
			ce_24  <= 1'b0;
			ce_32  <= 1'b0;
		end else begin
			div_24 <= div_24 + 2'd1;
			// wrap after count 2
			div_32 <= (div_32 == 2'd2) ? 2'd0 : div_32 + 2'd1;
			// pulse while the counter sits at zero
			ce_24  <= (div_24 == 2'd0);
			ce_32  <= (div_32 == 2'd0);
		end
	end

endmodule

/* logic/joystick_router.sv */
// joystick to core port routing
`timescale 1ns/1ps

module joystick_router (
	input  beeb_pkg::axis_pair_t pos,
	input  logic                 emu_on,
	input  logic                 emu_fire,
	input  beeb_pkg::axis_pair_t joy1_axes,
	input  beeb_pkg::axis_pair_t joy2_axes,
	input  logic [15:0]          joy1_btn,
	input  logic [15:0]          joy2_btn,
	input  logic                 swap_joy,
	output logic                 joy1_active,
	output beeb_pkg::beeb_joy_t  joy_a,
	output beeb_pkg::beeb_joy_t  joy_b
);

	beeb_pkg::axis_pair_t sel_a;
	logic                 fire_a;
	beeb_pkg::beeb_joy_t  src_a;
	beeb_pkg::beeb_joy_t  src_b;

	// signed centre to the core's inverted offset-binary axis
	// low nibble repeats the top to fill 12 bits
	function automatic logic [11:0] beeb_axis(input logic [7:0] v);
		logic [7:0] u;
		u = 8'hff - {~v[7], v[6:0]};
		return {u, u[7:4]};
	endfunction

	// ========================================
	// source a
	// ========================================
	// any button press hands port a back to the pad
	assign joy1_active = |joy1_btn;

	assign sel_a  = emu_on ? pos : joy1_axes;
	assign fire_a = emu_on ? emu_fire : joy1_btn[4];

	assign src_a.x      = beeb_axis(sel_a.x);
	assign src_a.y      = beeb_axis(sel_a.y);
	assign src_a.fire_n = ~fire_a;

	// ========================================
	// source b
	// ========================================
	assign src_b.x      = beeb_axis(joy2_axes.x);
	assign src_b.y      = beeb_axis(joy2_axes.y);
	assign src_b.fire_n = ~joy2_btn[4];

	// port swap
	assign joy_a = swap_joy ? src_b : src_a;
	assign joy_b = swap_joy ? src_a : src_b;

endmodule

/* logic/mouse_axis_emu.sv */
// mouse to analog joystick
`timescale 1ns/1ps

module mouse_axis_emu #(
	parameter int MOUSE_STEP_MAX = 10
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  beeb_pkg::mouse_pkt_t mouse,
	input  logic                 joy1_active,
	input  logic                 reset_req,
	input  logic                 mouse_off,
	output beeb_pkg::axis_pair_t pos,
	output logic                 emu_on,
	output logic                 emu_fire
);

	// ========================================
	// limits
	// ========================================
	localparam logic signed [8:0] STEP_HI  = 9'(MOUSE_STEP_MAX);
	localparam logic signed [8:0] STEP_LO  = -STEP_HI;
	localparam logic signed [8:0] RANGE_HI = 9'sd127;
	localparam logic signed [8:0] RANGE_LO = -9'sd128;

	logic              stb_q;
	logic              emu_q;
	logic signed [7:0] pos_x_q;
	logic signed [7:0] pos_y_q;
	logic              pkt_new;
	logic              clear;
	logic signed [8:0] dx_raw;
	logic signed [8:0] dy_raw;
	logic signed [8:0] sum_x;
	logic signed [8:0] sum_y;

	// per-packet movement limit
	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] v);
		if (v > STEP_HI)
			return STEP_HI;
		else if (v < STEP_LO)
			return STEP_LO;
		return v;
	endfunction

	// saturate back into one signed byte
	function automatic logic signed [7:0] clamp_range(input logic signed [8:0] v);
		if (v > RANGE_HI)
			return RANGE_HI[7:0];
		else if (v < RANGE_LO)
			return RANGE_LO[7:0];
		return v[7:0];
	endfunction

	// ========================================
	// movement
	// ========================================
	// sign bit from the status byte extends each count
	assign dx_raw = {mouse.x_sign, mouse.x_mov};
	assign dy_raw = {mouse.y_sign, mouse.y_mov};

	// screen y runs opposite to mouse y
	assign sum_x = pos_x_q + clamp_step(dx_raw);
	assign sum_y = pos_y_q - clamp_step(dy_raw);

	assign pkt_new = (stb_q != mouse.strobe);
	assign clear   = joy1_active || reset_req || mouse_off;

	// ========================================
	// accumulator
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			// track the strobe so a stale level is no packet
			stb_q   <= mouse.strobe;
			emu_q   <= 1'b0;
			pos_x_q <= 8'sd0;
			pos_y_q <= 8'sd0;
		end else begin
			stb_q <= mouse.strobe;
			// real joystick or disable wins over a packet
			if (clear) begin
				emu_q   <= 1'b0;
				pos_x_q <= 8'sd0;
				pos_y_q <= 8'sd0;
			end else if (pkt_new) begin
				emu_q   <= 1'b1;
				pos_x_q <= clamp_range(sum_x);
				pos_y_q <= clamp_range(sum_y);
			end
		end
	end

	assign pos.x    = pos_x_q;
	assign pos.y    = pos_y_q;
	assign emu_on   = emu_q;
	// left or right button fires
	assign emu_fire = |mouse.btn;

endmodule

/* logic/rom_image.sv */
// rom store with model bank remap
`timescale 1ns/1ps

module rom_image (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  beeb_pkg::rom_load_t rom_load,
	input  logic                model,
	input  beeb_pkg::mem_addr_t addr,
	output logic [7:0]          rom_byte
);

	// ========================================
	// storage
	// ========================================
	// 16-bit words, two rom bytes each
	logic [15:0]                 rom_mem [beeb_pkg::ROM_WORDS];

	// current bank lookup
	beeb_pkg::rom_slot_t         map;
	logic [beeb_pkg::ROM_AW-1:0] rd_word_addr;

	// read pipeline
	logic [15:0]                 rd_word;
	logic                        hit_q;
	logic                        odd_q;

	// ========================================
	// address remap
	// ========================================
	assign map = beeb_pkg::rom_slot_of(model, {addr.rom.grp, addr.rom.idx});

	// slot picks the 16 KB window
	// offset drops its byte bit to index words
	assign rd_word_addr = {map.slot, addr.rom.offset[13:1]};

	// ========================================
	// word array
	// ========================================
	always_ff @(posedge clk_sys) begin
		// loader only owns the store while the core is held
		if (!rst_n && rom_load.wr)
			rom_mem[rom_load.addr] <= rom_load.data;
		rd_word <= rom_mem[rd_word_addr];
	end

	// hit and byte lane follow the word by one cycle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hit_q <= 1'b0;
			odd_q <= 1'b0;
		end else begin
			hit_q <= map.hit;
			odd_q <= addr.rom.offset[0];
		end
	end

	// ========================================
	// byte select
	// ========================================
	// even byte sits in the upper half
	// empty sockets read back as zero
	always_comb begin
		if (!hit_q)
			rom_byte = 8'h00;
		else if (odd_q)
			rom_byte = rd_word[7:0];
		else
			rom_byte = rd_word[15:8];
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the beeb_host testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module beeb_host_tb \
	-f beeb_host.f \
	-Mdir obj_dir -o beeb_host_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit "$build_status"
fi

./obj_dir/beeb_host_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
	echo "simulation failed with status $sim_status"
	exit "$sim_status"
fi

exit 0
